/* src/deoxys_pkg.sv */
package deoxys_pkg;

   typedef logic [7:0]   byte_t;
   typedef logic [127:0] block_t;   // Row 0 in bits 127..96, column 0 is the top byte of a row

   typedef struct packed {
      block_t tk1;
      block_t tk2;
      block_t tk3;
   } tweakey_t;

   typedef struct packed {
      tweakey_t tweakey;
      block_t   plaintext;
   } cipher_in_t;

   parameter int NUM_ROUNDS = 16;

   typedef logic [$clog2(NUM_ROUNDS+1)-1:0] round_idx_t;

   // Entry i serves round tweakey i, last one is the final addition
   parameter byte_t RCON [0:16] = '{
      8'h2f, 8'h5e, 8'hbc, 8'h63, 8'hc6, 8'h97, 8'h35, 8'h6a,
      8'hd4, 8'hb3, 8'h7d, 8'hfa, 8'hef, 8'hc5, 8'h91, 8'h39,
      8'h72
   };

   typedef enum logic [1:0] {
      LANE_PERM,
      LANE_LFSR2,
      LANE_LFSR3
   } lane_kind_e;

endpackage

/* src/deoxys_sbox.sv */
`timescale 1ns/1ps
module deoxys_sbox (
   input  deoxys_pkg::byte_t a,
   output deoxys_pkg::byte_t q
);
   logic [0:7]  x, s;   // Bit 0 is the byte MSB
   logic [21:1] u;      // Top linear layer
   logic [67:0] w;
   logic [8:0]  g;      // Inversion outputs shared by both product rows
   logic [17:0] p;

   assign x = a;
   assign q = s;

   // Top linear layer
   assign u[14] = x[3] ^ x[5];
   assign u[13] = x[0] ^ x[6];
   assign u[9]  = x[0] ^ x[3];
   assign u[8]  = x[0] ^ x[5];
   assign w[0]  = x[1] ^ x[2];
   assign u[1]  = w[0] ^ x[7];
   assign u[4]  = u[1] ^ x[3];
   assign u[12] = u[13] ^ u[14];
   assign u[2]  = u[1] ^ x[0];
   assign u[5]  = u[1] ^ x[6];
   assign u[3]  = u[5] ^ u[8];
   assign w[1]  = x[4] ^ u[12];
   assign u[15] = w[1] ^ x[5];
   assign u[20] = w[1] ^ x[1];
   assign u[6]  = u[15] ^ x[7];
   assign u[10] = u[15] ^ w[0];
   assign u[11] = u[20] ^ u[9];
   assign u[7]  = x[7] ^ u[11];
   assign u[17] = u[10] ^ u[11];
   assign u[19] = u[10] ^ u[8];
   assign u[16] = w[0] ^ u[11];
   assign u[21] = u[13] ^ u[16];
   assign u[18] = x[0] ^ u[16];

   // Nonlinear middle, GF(2^4) inversion
   assign w[2]  = u[12] & u[15];
   assign w[3]  = u[3] & u[6];
   assign w[4]  = w[3] ^ w[2];
   assign w[5]  = u[4] & x[7];
   assign w[6]  = w[5] ^ w[2];
   assign w[7]  = u[13] & u[16];
   assign w[8]  = u[5] & u[1];
   assign w[9]  = w[8] ^ w[7];
   assign w[10] = u[2] & u[7];
   assign w[11] = w[10] ^ w[7];
   assign w[12] = u[9] & u[11];
   assign w[13] = u[14] & u[17];
   assign w[14] = w[13] ^ w[12];
   assign w[15] = u[8] & u[10];
   assign w[16] = w[15] ^ w[12];
   assign w[17] = w[4] ^ w[14];
   assign w[18] = w[6] ^ w[16];
   assign w[19] = w[9] ^ w[14];
   assign w[20] = w[11] ^ w[16];
   assign w[21] = w[17] ^ u[20];
   assign w[22] = w[18] ^ u[19];
   assign w[23] = w[19] ^ u[21];
   assign w[24] = w[20] ^ u[18];
   assign w[25] = w[21] ^ w[22];
   assign w[26] = w[21] & w[23];
   assign w[27] = w[24] ^ w[26];
   assign w[28] = w[25] & w[27];
   assign w[29] = w[28] ^ w[22];
   assign w[30] = w[23] ^ w[24];
   assign w[31] = w[22] ^ w[26];
   assign w[32] = w[31] & w[30];
   assign w[33] = w[32] ^ w[24];
   assign w[34] = w[23] ^ w[33];
   assign w[35] = w[27] ^ w[33];
   assign w[36] = w[24] & w[35];
   assign w[37] = w[36] ^ w[34];
   assign w[38] = w[27] ^ w[36];
   assign w[39] = w[29] & w[38];
   assign w[40] = w[25] ^ w[39];
   assign w[41] = w[40] ^ w[37];
   assign w[42] = w[29] ^ w[33];
   assign w[43] = w[29] ^ w[40];
   assign w[44] = w[33] ^ w[37];
   assign w[45] = w[42] ^ w[41];

   assign g = {w[41], w[45], w[42], w[29], w[40], w[43], w[33], w[37], w[44]};

   // Map back to GF(2^8), two rows of products
   assign p[8:0]  = g & {u[10], u[17], u[11], u[7], u[1], u[16], x[7], u[6], u[15]};
   assign p[17:9] = g & {u[8], u[14], u[9], u[2], u[5], u[13], u[4], u[3], u[12]};

   // Bottom linear layer, affine constant folded into the inversions
   assign w[46] = p[15] ^ p[16];
   assign w[47] = p[10] ^ p[11];
   assign w[48] = p[5] ^ p[13];
   assign w[49] = p[9] ^ p[10];
   assign w[50] = p[2] ^ p[12];
   assign w[51] = p[2] ^ p[5];
   assign w[52] = p[7] ^ p[8];
   assign w[53] = p[0] ^ p[3];
   assign w[54] = p[6] ^ p[7];
   assign w[55] = p[16] ^ p[17];
   assign w[56] = p[12] ^ w[48];
   assign w[57] = w[50] ^ w[53];
   assign w[58] = p[4] ^ w[46];
   assign w[59] = p[3] ^ w[54];
   assign w[60] = w[46] ^ w[57];
   assign w[61] = p[14] ^ w[57];
   assign w[62] = w[52] ^ w[58];
   assign w[63] = w[49] ^ w[58];
   assign w[64] = p[4] ^ w[59];
   assign w[65] = w[61] ^ w[62];
   assign w[66] = p[1] ^ w[63];
   assign w[67] = w[64] ^ w[65];

   assign s[0] = w[59] ^ w[63];
   assign s[3] = w[53] ^ w[66];
   assign s[4] = w[51] ^ w[66];
   assign s[5] = w[47] ^ w[65];
   assign s[6] = ~w[56] ^ w[62];
   assign s[7] = ~w[48] ^ w[60];
   assign s[1] = ~w[64] ^ s[3];
   assign s[2] = ~w[55] ^ w[67];

endmodule

/* src/deoxys_round.sv */
`timescale 1ns/1ps
module deoxys_round (
   input  deoxys_pkg::block_t state_in,
   input  deoxys_pkg::block_t round_tweakey,
   output deoxys_pkg::block_t state_out
);
   deoxys_pkg::block_t sub;
   deoxys_pkg::block_t shr;
   deoxys_pkg::block_t x2;
   deoxys_pkg::block_t x3;
   deoxys_pkg::block_t mix;

   for (genvar j = 0; j < 16; j++) begin : g_sub
      deoxys_sbox u_sbox (
         .a (state_in[8*j +: 8]),
         .q (sub[8*j +: 8])
      );
   end

   // Row r rotates left by r bytes
   assign shr[127:96] = sub[127:96];
   assign shr[95:64]  = {sub[87:64], sub[95:88]};
   assign shr[63:32]  = {sub[47:32], sub[63:48]};
   assign shr[31:0]   = {sub[7:0], sub[31:8]};

   for (genvar j = 0; j < 16; j++) begin : g_xtime
      assign x2[8*j +: 8] = {shr[8*j +: 7], 1'b0} ^ (shr[8*j+7] ? 8'h1b : 8'h00);
      assign x3[8*j +: 8] = x2[8*j +: 8] ^ shr[8*j +: 8];
   end

   // Whole rows at once, circulant (2 3 1 1)
   for (genvar r = 0; r < 4; r++) begin : g_mix
      assign mix[127-32*r -: 32] = x2[127-32*r -: 32]
                                 ^ x3[127-32*((r+1)%4) -: 32]
                                 ^ shr[127-32*((r+2)%4) -: 32]
                                 ^ shr[127-32*((r+3)%4) -: 32];
   end

   assign state_out = mix ^ round_tweakey;

endmodule

/* src/tweakey_lane.sv */
`timescale 1ns/1ps
module tweakey_lane #(
   parameter deoxys_pkg::lane_kind_e KIND = deoxys_pkg::LANE_PERM
) (
   input  deoxys_pkg::block_t lane_in,
   output deoxys_pkg::block_t lane_out
);
   // Source byte for each output byte, byte 15 first
   localparam int SRC [15:0] = '{2, 1, 0, 3, 15, 14, 13, 12, 8, 11, 10, 9, 5, 4, 7, 6};

   for (genvar k = 0; k < 16; k++) begin : g_byte
      deoxys_pkg::byte_t b;

      assign b = lane_in[8*SRC[k] +: 8];

      if (KIND == deoxys_pkg::LANE_LFSR2) begin : g_lfsr2
         assign lane_out[8*k +: 8] = {b[6:0], b[7] ^ b[5]};
      end else if (KIND == deoxys_pkg::LANE_LFSR3) begin : g_lfsr3
         assign lane_out[8*k +: 8] = {b[0] ^ b[6], b[7:1]};
      end else begin : g_perm
         assign lane_out[8*k +: 8] = b;   // TK1 only permutes
      end
   end

endmodule

/* src/tweakey_schedule.sv */
`timescale 1ns/1ps
module tweakey_schedule #(
   parameter int NUM_ROUNDS = deoxys_pkg::NUM_ROUNDS
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,
   input  logic                   advance,
   input  deoxys_pkg::tweakey_t   tweakey_init,
   input  deoxys_pkg::round_idx_t round_idx,
   output deoxys_pkg::block_t     round_tweakey
);
   deoxys_pkg::tweakey_t lanes;      // Lane words for round_idx
   deoxys_pkg::tweakey_t lane_src;
   deoxys_pkg::tweakey_t lane_next;
   deoxys_pkg::tweakey_t rt_src;
   deoxys_pkg::byte_t    rc;
   deoxys_pkg::block_t   rc_word;
   logic                 live;

   assign lane_src = load ? tweakey_init : lanes;

   tweakey_lane #(.KIND(deoxys_pkg::LANE_PERM)) u_tk1 (
      .lane_in  (lane_src.tk1),
      .lane_out (lane_next.tk1)
   );

   tweakey_lane #(.KIND(deoxys_pkg::LANE_LFSR2)) u_tk2 (
      .lane_in  (lane_src.tk2),
      .lane_out (lane_next.tk2)
   );

   tweakey_lane #(.KIND(deoxys_pkg::LANE_LFSR3)) u_tk3 (
      .lane_in  (lane_src.tk3),
      .lane_out (lane_next.tk3)
   );

   always_ff @(posedge clk) begin
      if (load || advance) lanes <= lane_next;
   end

   // Lanes valid from load until the last round
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         live <= 1'b0;
      end else if (load) begin
         live <= 1'b1;
      end else if (advance && round_idx == deoxys_pkg::round_idx_t'(NUM_ROUNDS)) begin
         live <= 1'b0;
      end
   end

   assign rt_src  = live ? lanes : tweakey_init;   // Round 0 straight from the input
   assign rc      = deoxys_pkg::RCON[round_idx];
   assign rc_word = {8'h01, rc, 16'h0000, 8'h02, rc, 16'h0000,
                     8'h04, rc, 16'h0000, 8'h08, rc, 16'h0000};

   assign round_tweakey = rt_src.tk1 ^ rt_src.tk2 ^ rt_src.tk3 ^ rc_word;

endmodule

/* src/deoxys_core.sv */
`timescale 1ns/1ps
module deoxys_core #(
   parameter int NUM_ROUNDS = deoxys_pkg::NUM_ROUNDS
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  deoxys_pkg::cipher_in_t in_data,
   output logic                   out_valid,
   input  logic                   out_ready,
   output deoxys_pkg::block_t     out_block
);
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } fsm_e;

   fsm_e                   fsm;
   deoxys_pkg::round_idx_t round_idx;
   deoxys_pkg::block_t     state_q;
   deoxys_pkg::block_t     round_tweakey;
   deoxys_pkg::block_t     round_out;
   logic                   accept;
   logic                   last_round;

   assign in_ready   = (fsm == IDLE);
   assign out_valid  = (fsm == DONE);
   assign accept     = in_valid & in_ready;
   assign last_round = (fsm == RUN) && (round_idx == deoxys_pkg::round_idx_t'(NUM_ROUNDS));
   assign out_block  = state_q;

   tweakey_schedule #(.NUM_ROUNDS(NUM_ROUNDS)) u_schedule (
      .clk           (clk),
      .arst_n        (arst_n),
      .load          (accept),
      .advance       (fsm == RUN),
      .tweakey_init  (in_data.tweakey),
      .round_idx     (round_idx),
      .round_tweakey (round_tweakey)
   );

   deoxys_round u_round (
      .state_in      (state_q),
      .round_tweakey (round_tweakey),
      .state_out     (round_out)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fsm       <= IDLE;
         round_idx <= '0;
      end else begin
         case (fsm)
            IDLE: begin
               if (accept) begin
                  fsm       <= RUN;
                  round_idx <= deoxys_pkg::round_idx_t'(1);   // Round 0 folds into the load
               end
            end
            RUN: begin
               if (last_round) begin
                  fsm       <= DONE;
                  round_idx <= '0;
               end else begin
                  round_idx <= round_idx + 1'b1;
               end
            end
            DONE: begin
               if (out_ready) fsm <= IDLE;   // Held here under back-pressure
            end
            default: fsm <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         state_q <= in_data.plaintext ^ round_tweakey;
      end else if (fsm == RUN) begin
         state_q <= round_out;
      end
   end

endmodule

/* verification/deoxys_ref_model.svh */
`ifndef DEOXYS_REF_MODEL_SVH
`define DEOXYS_REF_MODEL_SVH

localparam int MODEL_ROUNDS = 16;

deoxys_pkg::byte_t sbox_tbl [0:255];

initial $readmemh("verification/aes_sbox.hex", sbox_tbl);

function automatic deoxys_pkg::byte_t mul2(input deoxys_pkg::byte_t b);
   return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// Kind 1 is TK1, 2 is TK2, 3 is TK3
function automatic deoxys_pkg::block_t next_lane(input deoxys_pkg::block_t w, input int kind);
   int                 src [0:15];
   deoxys_pkg::block_t p;
   deoxys_pkg::byte_t  b;
   src = '{2, 1, 0, 3, 15, 14, 13, 12, 8, 11, 10, 9, 5, 4, 7, 6};   // Byte 15 first
   for (int n = 0; n < 16; n++) begin
      b = w[8*src[n] +: 8];
      if (kind == 2) b = {b[6:0], b[7] ^ b[5]};
      else if (kind == 3) b = {b[0] ^ b[6], b[7:1]};
      p[8*(15-n) +: 8] = b;
   end
   return p;
endfunction

function automatic deoxys_pkg::block_t round_const(input int i);
   deoxys_pkg::byte_t  rc_list [0:16];
   deoxys_pkg::block_t w;
   rc_list = '{8'h2f, 8'h5e, 8'hbc, 8'h63, 8'hc6, 8'h97, 8'h35, 8'h6a, 8'hd4,
               8'hb3, 8'h7d, 8'hfa, 8'hef, 8'hc5, 8'h91, 8'h39, 8'h72};
   w = '0;
   for (int row = 0; row < 4; row++) begin
      w[127-32*row -: 8] = 8'h01 << row;
      w[119-32*row -: 8] = rc_list[i];
   end
   return w;
endfunction

function automatic deoxys_pkg::block_t cipher_round(input deoxys_pkg::block_t s,
                                                     input deoxys_pkg::block_t rt);
   deoxys_pkg::byte_t  m [4][4];
   deoxys_pkg::byte_t  t [4][4];
   deoxys_pkg::block_t o;
   for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
         m[r][c] = sbox_tbl[s[127-8*(4*r+c) -: 8]];
   for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
         t[r][c] = m[r][(c+r)%4];
   for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
         o[127-8*(4*r+c) -: 8] = mul2(t[r][c]) ^ mul2(t[(r+1)%4][c]) ^ t[(r+1)%4][c]
                                 ^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
   return o ^ rt;
endfunction

function automatic deoxys_pkg::block_t ref_encrypt(input deoxys_pkg::cipher_in_t d);
   deoxys_pkg::block_t k1, k2, k3, st;
   k1 = d.tweakey.tk1;
   k2 = d.tweakey.tk2;
   k3 = d.tweakey.tk3;
   st = d.plaintext ^ k1 ^ k2 ^ k3 ^ round_const(0);
   for (int i = 1; i <= MODEL_ROUNDS; i++) begin
      k1 = next_lane(k1, 1);
      k2 = next_lane(k2, 2);
      k3 = next_lane(k3, 3);
      st = cipher_round(st, k1 ^ k2 ^ k3 ^ round_const(i));
   end
   return st;
endfunction

`endif

/* verification/tb_deoxys_core.sv */
`timescale 1ns/1ps
module tb_deoxys_core;
   localparam int WAIT_LIMIT = 400;

   logic                   clk;
   logic                   arst_n;
   logic                   in_valid;
   logic                   in_ready;
   deoxys_pkg::cipher_in_t in_data;
   logic                   out_valid;
   logic                   out_ready;
   deoxys_pkg::block_t     out_block;

   integer             seed;
   string              test_name;
   int                 n_assert, n_data, n_other;
   int                 n_in, n_out;
   int                 lat_cnt, cyc, ready_mode, mode_now, gap;
   bit                 stall_pat [0:1023];
   deoxys_pkg::block_t exp_q [$];
   deoxys_pkg::block_t exp_blk;

   `include "deoxys_ref_model.svh"

   deoxys_core DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_block (out_block)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Sink drives out_ready by mode
   always @(posedge clk) begin
      mode_now = ready_mode;
      cyc++;
      #1;
      case (mode_now)
         1: out_ready = 1'b1;                           // Always ready
         2: out_ready = stall_pat[cyc % 1024];          // Random stalls
         default: out_ready = 1'b0;                     // Stalled
      endcase
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) lat_cnt <= 0;
      else if (in_valid && in_ready) lat_cnt <= 0;   // Cycles since accept
      else lat_cnt <= lat_cnt + 1;
   end

   always @(posedge clk) begin
      if (arst_n && in_valid && in_ready) begin
         exp_q.push_back(ref_encrypt(in_data));
         n_in++;
      end
      if (arst_n && out_valid && out_ready) begin
         n_out++;
         if (exp_q.size() == 0) begin
            n_other++;
            $display("Error: output in test %s with no block outstanding", test_name);
         end else begin
            exp_blk = exp_q.pop_front();
            assert (out_block === exp_blk) else begin
               n_data++;
               $display("Fail %s expected %h actual %h", test_name, exp_blk, out_block);
            end
         end
      end
   end

   a_reset_out: assert property (@(posedge clk) !arst_n |-> !out_valid) else begin
      n_assert++;
      $display("Error: out_valid high during reset");
   end
   a_reset_rdy: assert property (@(posedge clk) $rose(arst_n) |-> in_ready && !out_valid)
      else begin
         n_assert++;
         $display("Error: DUT not idle and ready right after reset");
      end
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
         $rose(out_valid) |-> lat_cnt == MODEL_ROUNDS) else begin
      n_assert++;
      $display("Fail %s latency expected %0d actual %0d", test_name, MODEL_ROUNDS,
               $sampled(lat_cnt));
   end
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
         out_valid && !out_ready |=> out_valid && $stable(out_block)) else begin
      n_assert++;
      $display("Error: output changed while stalled in test %s", test_name);
   end
   a_busy: assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> !in_ready)
      else begin
         n_assert++;
         $display("Error: in_ready high while an output is pending in test %s", test_name);
      end

   function automatic deoxys_pkg::cipher_in_t random_input();
      deoxys_pkg::cipher_in_t d;
      for (int n = 0; n < 16; n++) d[32*n +: 32] = $random(seed);
      return d;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic finish_run();
      $display("Errors: %0d assertion, %0d data, %0d other", n_assert, n_data, n_other);
      if (n_assert + n_data + n_other == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   task automatic timeout_stop(input string what);
      n_other++;
      $display("Error: timeout in test %s while waiting for %s", test_name, what);
      finish_run();
   endtask

   task automatic send_block(input deoxys_pkg::cipher_in_t d);
      int waited;
      waited = 0;
      in_valid = 1'b1;
      in_data  = d;
      @(posedge clk);
      while (!in_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(posedge clk);
      end
      #1;
      in_valid = 1'b0;
      if (waited >= WAIT_LIMIT) timeout_stop("the input handshake");
   endtask

   task automatic wait_valid();
      int waited;
      waited = 0;
      while (!out_valid && waited < WAIT_LIMIT) begin
         waited++;
         next_cycle();
      end
      if (waited >= WAIT_LIMIT) timeout_stop("out_valid");
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (n_out < n_in && waited < WAIT_LIMIT) begin
         waited++;
         next_cycle();
      end
      if (waited >= WAIT_LIMIT) timeout_stop("all outputs");
   endtask

   initial begin
      seed       = 29;
      arst_n     = 1'b1;
      in_valid   = 1'b0;
      in_data    = '0;
      out_ready  = 1'b0;
      ready_mode = 0;
      test_name  = "reset";
      for (int n = 0; n < 1024; n++) stall_pat[n] = ($random(seed) % 3) != 0;
      #1;
      arst_n = 1'b0;   // Clean falling edge for the asynchronous reset
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      if (sbox_tbl[0] !== 8'h63) begin
         n_other++;
         $display("Error: S-box table file was not loaded");
      end
      next_cycle();

      test_name  = "single";
      ready_mode = 1;
      send_block(random_input());
      wait_drained();

      test_name  = "backpressure";
      ready_mode = 0;
      send_block(random_input());
      wait_valid();
      repeat (6) next_cycle();
      ready_mode = 1;
      wait_drained();

      test_name  = "stream";
      ready_mode = 2;
      for (int n = 0; n < 20; n++) begin
         gap = $unsigned($random(seed)) % 4;
         repeat (gap) next_cycle();
         send_block(random_input());
      end
      wait_drained();
      ready_mode = 1;

      test_name = "zero";
      send_block('0);
      wait_drained();

      assert (n_out == n_in && exp_q.size() == 0) else begin
         n_other++;
         $display("Fail count expected %0d actual %0d", n_in, n_out);
      end
      finish_run();
   end

endmodule

/* deoxys_core.f */
+incdir+verification
src/deoxys_pkg.sv
src/deoxys_sbox.sv
src/deoxys_round.sv
src/tweakey_lane.sv
src/tweakey_schedule.sv
src/deoxys_core.sv
verification/tb_deoxys_core.sv

/* verification/aes_sbox.hex */
// AES S-box, 16 bytes per line
// Line n holds the outputs for inputs 16n to 16n+15
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16
